// ==== mcu_pkg.sv ====
`default_nettype none

package mcu_pkg;

  localparam int addr_width = 16;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [15:0]           word_t;

  // i/o register map, word addresses
  localparam addr_t reg_timer_cnt = 16'h002;  // write loads, read gives count
  localparam addr_t reg_timer_ctl = 16'h004;  // [1] irq enable, [0] timeout
  localparam addr_t reg_uart_data = 16'h006;  // write sends low byte
  localparam addr_t reg_uart_ctl  = 16'h008;  // [2] tx_ready, [1] irq enable, [0] rx_ready

  // program loader
  localparam addr_t load_base     = 16'h300;  // first program word
  localparam word_t load_end_word = 16'h7fff; // terminates a load, never written

  // serial byte that arms the loader
  localparam logic [7:0] prog_esc = 8'h1b;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int clks_per_bit = 8
) (
  input  logic       rst,
  input  logic       clk,
  input  logic       rx,
  input  logic       loading,
  output logic [7:0] rx_byte,
  output logic       rx_strobe,
  output logic       esc_strobe
);

  import mcu_pkg::*;

  localparam int half_bit  = clks_per_bit / 2;
  // mid of last data bit to just before the end of the stop bit
  localparam int stop_wait = clks_per_bit + half_bit - 3;
  localparam int cnt_w     = $clog2(2 * clks_per_bit);

  typedef enum logic [1:0] {
    s_idle,
    s_start,
    s_data,
    s_stop
  } state_t;

  state_t           state;
  logic [1:0]       sync;    // line synchronizer
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;
  logic             sample;  // mid-bit point of a data bit
  logic             done;
  logic             is_esc;

  assign sample  = (state == s_data) && (cnt == '0);
  assign done    = (state == s_stop) && (cnt == '0);
  assign is_esc  = !loading && (shreg == prog_esc);
  assign rx_byte = shreg;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sync       <= 2'b11;
      state      <= s_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      rx_strobe  <= 1'b0;
      esc_strobe <= 1'b0;
    end else begin
      sync       <= {sync[0], rx};
      rx_strobe  <= done && !is_esc;
      esc_strobe <= done && is_esc;  // escape byte is swallowed here
      case (state)
        s_idle:
          if (!sync[1]) begin
            state <= s_start;
            cnt   <= cnt_w'(half_bit - 1);
          end
        s_start:
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else if (!sync[1]) begin
            state   <= s_data;
            cnt     <= cnt_w'(clks_per_bit - 1);
            bit_idx <= '0;
          end else begin
            state <= s_idle;  // glitch, not a start bit
          end
        s_data:
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= s_stop;
              cnt   <= cnt_w'(stop_wait - 1);
            end else begin
              cnt <= cnt_w'(clks_per_bit - 1);
            end
          end
        s_stop:
          if (cnt != '0)
            cnt <= cnt - 1'b1;
          else
            state <= s_idle;
        default:
          state <= s_idle;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge rst) begin
    if (sample)
      shreg <= {sync[1], shreg[7:1]};
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int clks_per_bit = 8
) (
  input  logic       rst,
  input  logic       clk,
  input  logic       wr,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_ready
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  logic             busy;
  logic [cnt_w-1:0] cnt;
  logic [3:0]       nbits;  // bits already put on the line after start
  logic [8:0]       shreg;  // data bits then stop bit
  logic             start;
  logic             bit_end;
  logic             shift;

  assign start    = wr && !busy;  // writes while busy are dropped
  assign bit_end  = busy && (cnt == '0);
  assign shift    = bit_end && (nbits != 4'd9);
  assign tx_ready = !busy;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      busy  <= 1'b0;
      tx    <= 1'b1;
      cnt   <= '0;
      nbits <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      tx    <= 1'b0;  // start bit
      cnt   <= cnt_w'(clks_per_bit - 1);
      nbits <= '0;
    end else if (busy && cnt != '0) begin
      cnt <= cnt - 1'b1;
    end else if (shift) begin
      tx    <= shreg[0];
      nbits <= nbits + 1'b1;
      cnt   <= cnt_w'(clks_per_bit - 1);
    end else if (bit_end) begin
      busy <= 1'b0;  // stop bit finished
    end
  end

  always_ff @(posedge rst) begin
    if (start)
      shreg <= {1'b1, tx_byte};
    else if (shift)
      shreg <= {1'b1, shreg[8:1]};
  end

endmodule

`default_nettype wire

// ==== cdtimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdtimer #(
  parameter int tick_clks = 1000
) (
  input  logic           rst,
  input  logic           clk,
  input  logic           core_rst,
  input  logic           load,
  input  mcu_pkg::word_t data,
  output mcu_pkg::word_t count,
  output logic           timeout
);

  localparam int pre_w = (tick_clks > 1) ? $clog2(tick_clks) : 1;

  logic [pre_w-1:0] pre;    // prescaler
  logic             tick;
  logic             armed;  // set by the first load

  assign tick    = (pre == pre_w'(tick_clks - 1));
  assign timeout = armed && (count == '0);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pre   <= '0;
      count <= '0;
      armed <= 1'b0;
    end else if (core_rst) begin
      pre   <= '0;
      count <= '0;
      armed <= 1'b0;
    end else if (load) begin
      pre   <= '0;  // restart the tick period on load
      count <= data;
      armed <= 1'b1;
    end else begin
      pre <= tick ? '0 : pre + 1'b1;
      if (tick && count != '0)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== prog_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_loader (
  input  logic           rst,
  input  logic           clk,
  input  logic           esc_strobe,
  input  logic           rx_strobe,
  input  logic [7:0]     rx_byte,
  output logic           loading,
  output mcu_pkg::addr_t load_addr,
  output mcu_pkg::word_t load_wdata,
  output logic           load_wr
);

  import mcu_pkg::*;

  logic phase;    // high while waiting for the low byte
  logic word_v;   // word complete, one cycle
  logic take;
  logic end_word;

  assign take     = loading && rx_strobe;
  assign end_word = word_v && (load_wdata == load_end_word);
  assign load_wr  = word_v && !end_word;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      loading   <= 1'b0;
      phase     <= 1'b0;
      word_v    <= 1'b0;
      load_addr <= load_base;
    end else begin
      word_v <= take && phase;
      if (!loading) begin
        phase     <= 1'b0;
        load_addr <= load_base;
        if (esc_strobe)
          loading <= 1'b1;
      end else begin
        if (take)
          phase <= !phase;
        if (end_word)
          loading <= 1'b0;  // releases the core next cycle
        else if (load_wr)
          load_addr <= load_addr + addr_t'(2);
      end
    end
  end

  // high byte arrives first
  always_ff @(posedge rst) begin
    if (take)
      load_wdata <= {load_wdata[7:0], rx_byte};
  end

endmodule

`default_nettype wire

// ==== io_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  logic           rst,
  input  logic           clk,
  input  mcu_pkg::addr_t cpu_addr,
  input  logic           cpu_rd,
  input  logic           cpu_wr,
  input  logic           cpu_byt,
  input  mcu_pkg::word_t cpu_wdata,
  output mcu_pkg::word_t cpu_rdata,
  input  logic           loading,
  input  mcu_pkg::addr_t load_addr,
  input  mcu_pkg::word_t load_wdata,
  input  logic           load_wr,
  output mcu_pkg::addr_t mem_addr,
  output logic           mem_wr,
  output logic           mem_byt,
  output mcu_pkg::word_t mem_wdata,
  input  mcu_pkg::word_t mem_rdata,
  input  mcu_pkg::word_t timer_count,
  input  logic           timeout,
  output logic           timer_load,
  input  logic [7:0]     rx_byte,
  input  logic           rx_strobe,
  output logic           tx_wr,
  input  logic           tx_ready,
  output logic           irq,
  output logic           core_rst
);

  import mcu_pkg::*;

  logic       rd_en;
  logic       wr_en;
  logic       is_reg;
  addr_t      addr_q;    // read address of the previous cycle
  logic       timer_ie;
  logic       uart_ie;
  logic       rx_ready;
  logic [7:0] rx_data;   // last received byte

  // cpu is held in reset while loading
  assign rd_en  = cpu_rd && !loading;
  assign wr_en  = cpu_wr && !loading;
  assign is_reg = cpu_addr inside {reg_timer_cnt, reg_timer_ctl, reg_uart_data, reg_uart_ctl};

  assign timer_load = wr_en && (cpu_addr == reg_timer_cnt);
  assign tx_wr      = wr_en && (cpu_addr == reg_uart_data);

  // memory bus, loader takes over while active
  assign mem_addr  = loading ? load_addr : cpu_addr;
  assign mem_wr    = loading ? load_wr : (wr_en && !is_reg);
  assign mem_byt   = loading ? 1'b0 : cpu_byt;
  assign mem_wdata = loading ? load_wdata : cpu_wdata;

  assign core_rst = loading;
  assign irq      = (timeout && timer_ie) || (rx_ready && uart_ie);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      addr_q   <= '0;
      timer_ie <= 1'b0;
      uart_ie  <= 1'b0;
      rx_ready <= 1'b0;
    end else begin
      addr_q <= cpu_addr;
      if (loading) begin
        timer_ie <= 1'b0;
        uart_ie  <= 1'b0;
        rx_ready <= 1'b0;
      end else begin
        if (wr_en && cpu_addr == reg_timer_ctl)
          timer_ie <= cpu_wdata[1];
        if (wr_en && cpu_addr == reg_uart_ctl)
          uart_ie <= cpu_wdata[1];
        if (rx_strobe)
          rx_ready <= 1'b1;  // new byte wins over a clear
        else if (rd_en && cpu_addr == reg_uart_data)
          rx_ready <= 1'b0;
        else if (wr_en && cpu_addr == reg_uart_ctl)
          rx_ready <= cpu_wdata[0];
      end
    end
  end

  always_ff @(posedge rst) begin
    if (rx_strobe && !loading)
      rx_data <= rx_byte;
  end

  always_comb begin
    case (addr_q)
      reg_timer_cnt: cpu_rdata = timer_count;
      reg_timer_ctl: cpu_rdata = {14'd0, timer_ie, timeout};
      reg_uart_data: cpu_rdata = {8'd0, rx_data};
      reg_uart_ctl:  cpu_rdata = {13'd0, tx_ready, uart_ie, rx_ready};
      default:       cpu_rdata = mem_rdata;  // memory answers in this cycle
    endcase
  end

endmodule

`default_nettype wire

// ==== mcu_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_io #(
  parameter int CLOCK_HZ        = 27_000_000,
  parameter int UART_BAUD       = 115_200,
  parameter int TIMER_TICK_CLKS = CLOCK_HZ / 1000
) (
  input  logic           rst,          // clock
  input  logic           clk,          // async reset, active high
  input  mcu_pkg::addr_t cpu_addr,
  input  logic           cpu_rd,
  input  logic           cpu_wr,
  input  logic           cpu_byt,
  input  mcu_pkg::word_t cpu_wdata,
  output mcu_pkg::word_t cpu_rdata,
  output logic           irq,
  output logic           core_rst,
  output mcu_pkg::addr_t mem_addr,
  output logic           mem_wr,
  output logic           mem_byt,
  output mcu_pkg::word_t mem_wdata,
  input  mcu_pkg::word_t mem_rdata,
  input  logic           uart_rx_line,
  output logic           uart_tx_line
);

  import mcu_pkg::*;

  localparam int clks_per_bit = CLOCK_HZ / UART_BAUD;

  logic [7:0] rx_byte;
  logic       rx_strobe;
  logic       esc_strobe;
  logic       loading;
  addr_t      load_addr;
  word_t      load_wdata;
  logic       load_wr;
  logic       tx_wr;
  logic       tx_ready;
  logic       timer_load;
  word_t      timer_count;
  logic       timeout;

  uart_rx #(.clks_per_bit(clks_per_bit)) rx0 (
    .rst(rst), .clk(clk), .rx(uart_rx_line), .loading(loading),
    .rx_byte(rx_byte), .rx_strobe(rx_strobe), .esc_strobe(esc_strobe)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) tx0 (
    .rst(rst), .clk(clk), .wr(tx_wr), .tx_byte(cpu_wdata[7:0]),
    .tx(uart_tx_line), .tx_ready(tx_ready)
  );

  cdtimer #(.tick_clks(TIMER_TICK_CLKS)) timer0 (
    .rst(rst), .clk(clk), .core_rst(core_rst), .load(timer_load),
    .data(cpu_wdata), .count(timer_count), .timeout(timeout)
  );

  prog_loader loader0 (
    .rst(rst), .clk(clk), .esc_strobe(esc_strobe), .rx_strobe(rx_strobe),
    .rx_byte(rx_byte), .loading(loading), .load_addr(load_addr),
    .load_wdata(load_wdata), .load_wr(load_wr)
  );

  io_regs regs0 (
    .rst(rst), .clk(clk),
    .cpu_addr(cpu_addr), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_byt(cpu_byt),
    .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata),
    .loading(loading), .load_addr(load_addr), .load_wdata(load_wdata), .load_wr(load_wr),
    .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_byt(mem_byt), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .timer_count(timer_count), .timeout(timeout), .timer_load(timer_load),
    .rx_byte(rx_byte), .rx_strobe(rx_strobe), .tx_wr(tx_wr), .tx_ready(tx_ready),
    .irq(irq), .core_rst(core_rst)
  );

endmodule

`default_nettype wire

// ==== mcu_io_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_io_checker #(
  parameter int bit_clks    = 8,
  parameter int cycle_limit = 10000
) (
  input  logic           rst,            // clock
  input  logic           clk,            // reset
  input  mcu_pkg::addr_t mem_addr,
  input  logic           mem_wr,
  input  logic           mem_byt,
  input  mcu_pkg::word_t mem_wdata,
  input  logic           uart_tx_line,
  output logic [15:0]    tx_frames,
  output logic [15:0]    error_count,
  output logic           timed_out
);

  import mcu_pkg::*;

  addr_t      exp_addr[$];
  word_t      exp_data[$];
  logic       exp_byt[$];
  logic [7:0] exp_tx[$];
  int         cycles;
  int         test_errors;   // errors since the last finished test
  int         tests_passed;
  int         tests_failed;

  initial begin
    tx_frames    = '0;
    error_count  = '0;
    timed_out    = 1'b0;
    cycles       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
  end

  task automatic note_error();
    error_count = error_count + 1'b1;
    test_errors = test_errors + 1;
  endtask

  task automatic compare(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected 0x%04h, actual 0x%04h", name, exp, act);
      note_error();
    end
  endtask

  task automatic fail_msg(input string what);
    $display("%s", what);
    note_error();
  endtask

  task automatic expect_write(input addr_t a, input word_t d, input logic byt);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    exp_byt.push_back(byt);
  endtask

  task automatic expect_tx(input logic [7:0] b);
    exp_tx.push_back(b);
  endtask

  task automatic check_drained(input string name);
    if (exp_addr.size() != 0)
      fail_msg($sformatf("%s: %0d expected memory writes never happened", name, exp_addr.size()));
    if (exp_tx.size() != 0)
      fail_msg($sformatf("%s: %0d expected serial frames never sent", name, exp_tx.size()));
    exp_addr.delete();
    exp_data.delete();
    exp_byt.delete();
    exp_tx.delete();
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("PASS %s", name);
      tests_passed = tests_passed + 1;
    end else begin
      $display("FAIL %s (%0d errors)", name, test_errors);
      tests_failed = tests_failed + 1;
    end
    test_errors = 0;
  endtask

  task automatic report();
    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, error_count);
  endtask

  // memory writes from the cpu side or the loader
  always @(posedge rst) begin
    if (!clk && mem_wr) begin
      if (exp_addr.size() == 0) begin
        fail_msg($sformatf("unexpected memory write to 0x%04h", mem_addr));
      end else begin
        compare("mem_wr_addr", exp_addr.pop_front(), mem_addr);
        compare("mem_wr_data", exp_data.pop_front(), mem_wdata);
        compare("mem_wr_byt", {15'd0, exp_byt.pop_front()}, {15'd0, mem_byt});
      end
    end
  end

  // serial decoder, samples mid bit
  initial begin
    logic [7:0] b;
    forever begin
      @(negedge uart_tx_line);
      if (!clk) begin
        repeat (bit_clks / 2) @(posedge rst);
        if (uart_tx_line)
          fail_msg("serial start bit too short");
        for (int i = 0; i < 8; i++) begin
          repeat (bit_clks) @(posedge rst);
          b[i] = uart_tx_line;
        end
        repeat (bit_clks) @(posedge rst);
        if (!uart_tx_line)
          fail_msg("serial stop bit missing");
        if (exp_tx.size() == 0)
          fail_msg($sformatf("unexpected serial frame 0x%02h", b));
        else
          compare("uart_tx_byte", {8'd0, exp_tx.pop_front()}, {8'd0, b});
        tx_frames = tx_frames + 1'b1;
      end
    end
  end

  always @(posedge rst) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit && !timed_out) begin
      $display("run stopped, no end after %0d cycles", cycle_limit);
      error_count = error_count + 1'b1;
      timed_out   = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== tb_mcu_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_io;

  import mcu_pkg::*;

  localparam int clock_hz   = 1_000_000;
  localparam int uart_baud  = 125_000;
  localparam int tick_clks  = 16;
  localparam int bit_clks   = clock_hz / uart_baud;
  localparam int load_words = 4;
  localparam int max_count  = 8;
  // tx 1, rx 1, escape 1, words, end word 2
  localparam int frames      = 5 + 2 * load_words;
  localparam int cycle_limit = 2 * (frames * 10 * bit_clks + max_count * tick_clks + 300);

  logic        rst;   // clock
  logic        clk;   // reset
  addr_t       cpu_addr;
  logic        cpu_rd;
  logic        cpu_wr;
  logic        cpu_byt;
  word_t       cpu_wdata;
  word_t       cpu_rdata;
  logic        irq;
  logic        core_rst;
  addr_t       mem_addr;
  logic        mem_wr;
  logic        mem_byt;
  word_t       mem_wdata;
  word_t       mem_rdata;
  logic        uart_rx_line;
  logic        uart_tx_line;
  logic [15:0] tx_frames;
  logic [15:0] error_count;
  logic        timed_out;

  word_t mem[addr_t];  // sparse, unwritten words come from fill_word

  mcu_io #(
    .CLOCK_HZ(clock_hz), .UART_BAUD(uart_baud), .TIMER_TICK_CLKS(tick_clks)
  ) dut0 (
    .rst(rst), .clk(clk),
    .cpu_addr(cpu_addr), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_byt(cpu_byt),
    .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .irq(irq), .core_rst(core_rst),
    .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_byt(mem_byt), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata), .uart_rx_line(uart_rx_line), .uart_tx_line(uart_tx_line)
  );

  mcu_io_checker #(.bit_clks(bit_clks), .cycle_limit(cycle_limit)) chk0 (
    .rst(rst), .clk(clk), .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_byt(mem_byt),
    .mem_wdata(mem_wdata), .uart_tx_line(uart_tx_line), .tx_frames(tx_frames),
    .error_count(error_count), .timed_out(timed_out)
  );

  always #4 rst = ~rst;

  function automatic word_t fill_word(input addr_t a);
    return {a[7:0], a[15:8]} ^ 16'h5a3c;
  endfunction

  function automatic word_t model_word(input addr_t a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  function automatic logic is_reg_addr(input addr_t a);
    return a == reg_timer_cnt || a == reg_timer_ctl || a == reg_uart_data || a == reg_uart_ctl;
  endfunction

  // synchronous memory, answers one cycle after the address
  always @(posedge rst) begin
    if (mem_wr)
      mem[mem_addr] = mem_wdata;
    mem_rdata <= model_word(mem_addr);
  end

  task automatic write_word(input addr_t a, input word_t d);
    @(posedge rst);
    cpu_addr  <= a;
    cpu_wdata <= d;
    cpu_wr    <= 1'b1;
    @(posedge rst);
    cpu_wr <= 1'b0;
  endtask

  task automatic read_word(input addr_t a, output word_t d);
    @(posedge rst);
    cpu_addr <= a;
    cpu_rd   <= 1'b1;
    @(posedge rst);
    cpu_rd <= 1'b0;
    @(negedge rst);
    d = cpu_rdata;
  endtask

  task automatic send_serial(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge rst);
      uart_rx_line <= frame[i];
      repeat (bit_clks - 1) @(posedge rst);
    end
    repeat (3) @(posedge rst);  // idle gap
  endtask

  initial begin
    word_t      d;
    word_t      w;
    word_t      prev;
    logic [7:0] b;
    int         n;
    int         waited;

    void'($urandom(32'hdbe2d943));
    rst          = 1'b0;
    clk          = 1'b1;
    cpu_addr     = '0;
    cpu_rd       = 1'b0;
    cpu_wr       = 1'b0;
    cpu_byt      = 1'b0;
    cpu_wdata    = '0;
    mem_rdata    = '0;
    uart_rx_line = 1'b1;
    repeat (10) @(posedge rst);
    clk <= 1'b0;

    // reset defaults
    read_word(reg_timer_ctl, d);
    chk0.compare("reset_timer_ctl", 16'h0000, d);
    read_word(reg_uart_ctl, d);
    chk0.compare("reset_uart_ctl", 16'h0004, d);
    chk0.compare("reset_tx_line", 16'd1, {15'd0, uart_tx_line});
    chk0.compare("reset_irq", 16'd0, {15'd0, irq});
    chk0.compare("reset_core_rst", 16'd0, {15'd0, core_rst});
    chk0.end_test("reset_defaults");

    // registers and memory pass-through
    w = word_t'($urandom);
    write_word(reg_timer_ctl, w);
    read_word(reg_timer_ctl, d);
    chk0.compare("timer_ctl_readback", {14'd0, w[1], 1'b0}, d);
    w = word_t'($urandom);
    write_word(reg_uart_ctl, w);
    read_word(reg_uart_ctl, d);
    chk0.compare("uart_ctl_readback", {13'd0, 1'b1, w[1], w[0]}, d);
    write_word(reg_uart_ctl, 16'h0000);
    write_word(reg_timer_ctl, 16'h0000);
    do w = word_t'($urandom); while (is_reg_addr(w));
    read_word(w, d);
    chk0.compare("mem_read", model_word(w), d);
    do w = word_t'($urandom); while (is_reg_addr(w));
    prev = word_t'($urandom);
    @(posedge rst);
    cpu_byt <= 1'b1;  // byte access from here on
    chk0.expect_write(w, prev, 1'b1);
    write_word(w, prev);
    read_word(w, d);
    chk0.compare("mem_write_readback", prev, d);
    chk0.check_drained("pass_through");
    chk0.end_test("register_pass_through");

    // uart transmit
    b = 8'($urandom);
    n = int'(tx_frames);
    chk0.expect_tx(b);
    write_word(reg_uart_data, {8'd0, b});
    read_word(reg_uart_ctl, d);
    chk0.compare("tx_busy", 16'd0, {15'd0, d[2]});
    waited = 0;
    while (int'(tx_frames) == n && waited < 20 * bit_clks) begin
      @(posedge rst);
      waited++;
    end
    if (int'(tx_frames) == n)
      chk0.fail_msg("uart transmit frame never seen");
    repeat (bit_clks) @(posedge rst);
    read_word(reg_uart_ctl, d);
    chk0.compare("tx_ready_after", 16'd1, {15'd0, d[2]});
    chk0.check_drained("uart_tx");
    chk0.end_test("uart_transmit");

    // uart receive
    do b = 8'($urandom); while (b == prog_esc);
    write_word(reg_uart_ctl, 16'h0002);
    send_serial(b);
    @(negedge rst);
    chk0.compare("rx_irq", 16'd1, {15'd0, irq});
    read_word(reg_uart_ctl, d);
    chk0.compare("rx_ready_set", 16'h0007, d);
    read_word(reg_uart_data, d);
    chk0.compare("rx_data", {8'd0, b}, d);
    read_word(reg_uart_ctl, d);
    chk0.compare("rx_ready_clear", 16'h0006, d);
    chk0.compare("rx_irq_clear", 16'd0, {15'd0, irq});
    write_word(reg_uart_ctl, 16'h0000);
    chk0.end_test("uart_receive");

    // countdown timer
    write_word(reg_timer_ctl, 16'h0002);
    n = 1 + int'($urandom % max_count);
    write_word(reg_timer_cnt, word_t'(n));
    read_word(reg_timer_cnt, d);
    chk0.compare("timer_load", word_t'(n), d);
    prev   = d;
    waited = 0;
    while (!irq && waited < n * tick_clks + 32) begin
      read_word(reg_timer_cnt, d);
      if (d > prev)
        chk0.fail_msg($sformatf("timer count went up from %0d to %0d", prev, d));
      prev = d;
      waited += 2;
    end
    chk0.compare("timer_irq", 16'd1, {15'd0, irq});
    read_word(reg_timer_ctl, d);
    chk0.compare("timer_timeout", 16'h0003, d);
    write_word(reg_timer_cnt, word_t'(n + 4));
    read_word(reg_timer_ctl, d);
    chk0.compare("timer_reload", 16'h0002, d);
    chk0.compare("timer_irq_clear", 16'd0, {15'd0, irq});
    write_word(reg_timer_ctl, 16'h0000);
    chk0.end_test("timer");

    // program load
    send_serial(prog_esc);
    @(negedge rst);
    chk0.compare("load_core_rst", 16'd1, {15'd0, core_rst});
    for (int k = 0; k < load_words; k++) begin
      w = word_t'($urandom);
      if (w == load_end_word)
        w = 16'h1234;
      chk0.expect_write(load_base + addr_t'(2 * k), w, 1'b0);
      send_serial(w[15:8]);
      send_serial(w[7:0]);
      @(negedge rst);
      chk0.compare("load_core_rst", 16'd1, {15'd0, core_rst});
    end
    send_serial(load_end_word[15:8]);
    send_serial(load_end_word[7:0]);
    @(negedge rst);
    chk0.compare("load_done_core_rst", 16'd0, {15'd0, core_rst});
    read_word(reg_uart_ctl, d);
    chk0.compare("load_rx_ready", 16'h0004, d);
    chk0.check_drained("program_load");
    chk0.end_test("program_load");

    chk0.report();
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  always @(posedge rst) begin
    if (timed_out) begin
      $display("Test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
mcu_pkg.sv
uart_rx.sv
uart_tx.sv
cdtimer.sv
prog_loader.sv
io_regs.sv
mcu_io.sv
mcu_io_checker.sv
tb_mcu_io.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mcu_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_mcu_io -o sim_mcu_io
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_mcu_io > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
